//--- axi_sram_consts.svh
//**********************************************************
// widths, memory depth and LFSR seed for the SRAM slave
//**********************************************************

`ifndef AXI_SRAM_CONSTS_SVH
`define AXI_SRAM_CONSTS_SVH

// byte address and data bus widths
`define AXS_ADDR_W 32
`define AXS_DATA_W 32

// one strobe bit per data byte
`define AXS_STRB_W (`AXS_DATA_W/8)

// word array size
`define AXS_MEM_DEPTH 256
`define AXS_IDX_W 8

// response delay generator start value
`define AXS_LFSR_SEED 4'h1

`endif

//--- axi_sram_pkg.sv
//**********************************************************
// shared types of the SRAM slave
// addresses, data words, strobes, word index, response code
//**********************************************************

`default_nettype none

`include "axi_sram_consts.svh"

package axi_sram_pkg;

	typedef logic [`AXS_ADDR_W-1:0] addr_t;    // byte address
	typedef logic [`AXS_DATA_W-1:0] data_t;
	typedef logic [`AXS_STRB_W-1:0] strb_t;    // byte enables
	typedef logic [`AXS_IDX_W-1:0]  idx_t;     // word index into the array

	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} resp_t;

endpackage

`default_nettype wire

//--- axi_sram_if.sv
//**********************************************************
// stage-to-stage interfaces of the SRAM slave
// stg_req_if  request stage to word array
// stg_rsp_if  word array to response stage
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

// one-cycle request pulse, issued only into an empty pipeline
interface stg_req_if
	import axi_sram_pkg::*;
();
	logic  valid;
	logic  is_write;
	idx_t  idx;
	data_t wdata;
	strb_t wstrb;
	logic  err;      // word index beyond the array

	modport src (output valid, is_write, idx, wdata, wstrb, err);
	modport dst (input  valid, is_write, idx, wdata, wstrb, err);
endinterface

// one-cycle result pulse from the array
interface stg_rsp_if
	import axi_sram_pkg::*;
();
	logic  valid;
	logic  is_write;
	data_t rdata;
	resp_t resp;

	modport src (output valid, is_write, rdata, resp);
	modport dst (input  valid, is_write, rdata, resp);
endinterface

`default_nettype wire

//--- delay_lfsr.sv
//**********************************************************
// 4-bit Fibonacci LFSR for the random response delay
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "axi_sram_consts.svh"

module delay_lfsr (
	input  logic       clk,
	input  logic       rstn,
	output logic [3:0] delay_o
);

	logic [3:0] lfsr_q;
	logic       fb;

	assign fb = lfsr_q[3] ^ lfsr_q[2];    // x^4 + x^3 + 1

	always_ff @(posedge clk) begin
		if (!rstn)
			lfsr_q <= `AXS_LFSR_SEED;
		else
			lfsr_q <= {lfsr_q[2:0], fb};
	end

	// state runs 1..15, shift down so a zero wait is possible
	assign delay_o = lfsr_q - 4'd1;

endmodule

`default_nettype wire

//--- axi_sram_req_stage.sv
//**********************************************************
// request stage of the SRAM slave
// AR / AW+W acceptance FSM, read priority, range check
// and the request register toward the array
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_req_stage
	import axi_sram_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,

	// read address
	input  addr_t ar_addr_i,
	input  logic  ar_valid_i,
	output logic  ar_ready_o,

	// write address
	input  addr_t aw_addr_i,
	input  logic  aw_valid_i,
	output logic  aw_ready_o,

	// write data
	input  data_t w_data_i,
	input  strb_t w_strb_i,
	input  logic  w_valid_i,
	output logic  w_ready_o,

	input  logic  done_i,    // R or B handshake finished

	stg_req_if.src req
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   rdy_q;       // high only while idle
	logic   rd_acc;
	logic   wr_acc;
	logic   acc;
	addr_t  acc_addr;
	addr_t  word_num;
	logic   addr_err;

	// read wins when both arrive together
	assign rd_acc = rdy_q & ar_valid_i;
	assign wr_acc = rdy_q & ~ar_valid_i & aw_valid_i & w_valid_i;
	assign acc    = rd_acc | wr_acc;

	assign ar_ready_o = rdy_q;
	// AW and W only complete as a pair, and never beside a read
	assign aw_ready_o = rdy_q & ~ar_valid_i & w_valid_i;
	assign w_ready_o  = rdy_q & ~ar_valid_i & aw_valid_i;

	assign acc_addr = rd_acc ? ar_addr_i : aw_addr_i;
	assign word_num = acc_addr >> 2;    // low two bits ignored
	assign addr_err = (word_num >= `AXS_MEM_DEPTH);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (acc)
					state_d = ST_BUSY;
			end
			ST_BUSY: begin
				if (done_i)
					state_d = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			rdy_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			rdy_q   <= (state_d == ST_IDLE);    // back up the cycle after done
		end
	end

	// request pulse, one cycle after the accept edge
	always_ff @(posedge clk) begin
		if (!rstn)
			req.valid <= 1'b0;
		else
			req.valid <= acc;
	end

	// payload captured on accept
	always_ff @(posedge clk) begin
		if (acc) begin
			req.is_write <= wr_acc;
			req.idx      <= acc_addr[`AXS_IDX_W+1:2];
			req.wdata    <= w_data_i;
			req.wstrb    <= w_strb_i;
			req.err      <= addr_err;
		end
	end

endmodule

`default_nettype wire

//--- axi_sram_array.sv
//**********************************************************
// byte-strobed word array with registered read
// turns each request pulse into a response token
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_array
	import axi_sram_pkg::*;
(
	input  logic   clk,
	input  logic   rstn,
	stg_req_if.dst req,
	stg_rsp_if.src rsp
);

	data_t mem [`AXS_MEM_DEPTH];

	// byte lane write, dropped on range error
	always_ff @(posedge clk) begin
		if (req.valid && req.is_write && !req.err) begin
			for (int b = 0; b < `AXS_STRB_W; b++) begin
				if (req.wstrb[b])
					mem[req.idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= req.valid;
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			rsp.is_write <= req.is_write;
			rsp.rdata    <= (req.err || req.is_write) ? '0 : mem[req.idx];    // zero on error
			rsp.resp     <= req.err ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

`default_nettype wire

//--- axi_sram_rsp_stage.sv
//**********************************************************
// response stage of the SRAM slave
// random delay countdown, R / B holding registers
// and the done pulse back to the request stage
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

module axi_sram_rsp_stage
	import axi_sram_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,

	stg_rsp_if.dst     rsp,
	input  logic [3:0] delay_i,    // from the LFSR

	// read data
	output data_t      r_data_o,
	output resp_t      r_resp_o,
	output logic       r_valid_o,
	input  logic       r_ready_i,

	// write response
	output resp_t      b_resp_o,
	output logic       b_valid_o,
	input  logic       b_ready_i,

	output logic       done_o
);

	logic       busy_q;     // response captured, not yet handed over
	logic [3:0] cnt_q;
	logic       wr_q;
	data_t      rdata_q;
	resp_t      resp_q;
	logic       fire;

	always_ff @(posedge clk) begin
		if (!rstn)
			busy_q <= 1'b0;
		else if (rsp.valid)
			busy_q <= 1'b1;
		else if (done_o)
			busy_q <= 1'b0;
	end

	// D loaded with the token, valid shows once it hits zero
	always_ff @(posedge clk) begin
		if (!rstn)
			cnt_q <= 4'd0;
		else if (rsp.valid)
			cnt_q <= delay_i;
		else if (busy_q && cnt_q != 4'd0)
			cnt_q <= cnt_q - 4'd1;
	end

	// held steady while the master stalls
	always_ff @(posedge clk) begin
		if (rsp.valid) begin
			wr_q    <= rsp.is_write;
			rdata_q <= rsp.rdata;
			resp_q  <= rsp.resp;
		end
	end

	assign fire = busy_q & (cnt_q == 4'd0);

	// channel chosen by the request kind
	assign r_valid_o = fire & ~wr_q;
	assign b_valid_o = fire & wr_q;

	assign r_data_o = rdata_q;
	assign r_resp_o = resp_q;
	assign b_resp_o = resp_q;

	// the completing handshake frees the request stage
	assign done_o = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i);

endmodule

`default_nettype wire

//--- axi_sram_top.sv
//**********************************************************
// top level of the AXI-lite style SRAM slave
// request stage, word array, response stage, delay LFSR
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

module axi_sram_top
	import axi_sram_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,

	input  addr_t ar_addr_i,
	input  logic  ar_valid_i,
	output logic  ar_ready_o,

	output data_t r_data_o,
	output resp_t r_resp_o,
	output logic  r_valid_o,
	input  logic  r_ready_i,

	input  addr_t aw_addr_i,
	input  logic  aw_valid_i,
	output logic  aw_ready_o,

	input  data_t w_data_i,
	input  strb_t w_strb_i,
	input  logic  w_valid_i,
	output logic  w_ready_o,

	output resp_t b_resp_o,
	output logic  b_valid_o,
	input  logic  b_ready_i
);

	logic [3:0] delay;
	logic       done;    // R/B handshake seen by the response stage

	stg_req_if req_if ();
	stg_rsp_if rsp_if ();

	axi_sram_req_stage u_req (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr_i),
		.ar_valid_i (ar_valid_i),
		.ar_ready_o (ar_ready_o),
		.aw_addr_i  (aw_addr_i),
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.w_data_i   (w_data_i),
		.w_strb_i   (w_strb_i),
		.w_valid_i  (w_valid_i),
		.w_ready_o  (w_ready_o),
		.done_i     (done),
		.req        (req_if.src)
	);

	axi_sram_array u_array (
		.clk  (clk),
		.rstn (rstn),
		.req  (req_if.dst),
		.rsp  (rsp_if.src)
	);

	axi_sram_rsp_stage u_rsp (
		.clk       (clk),
		.rstn      (rstn),
		.rsp       (rsp_if.dst),
		.delay_i   (delay),
		.r_data_o  (r_data_o),
		.r_resp_o  (r_resp_o),
		.r_valid_o (r_valid_o),
		.r_ready_i (r_ready_i),
		.b_resp_o  (b_resp_o),
		.b_valid_o (b_valid_o),
		.b_ready_i (b_ready_i),
		.done_o    (done)
	);

	delay_lfsr u_lfsr (
		.clk     (clk),
		.rstn    (rstn),
		.delay_o (delay)
	);

endmodule

`default_nettype wire

//--- axi_sram_sva.sv
//**********************************************************
// handshake assertions for the SRAM slave top level
// reset quiet, R/B hold under back-pressure, no overlap
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

module axi_sram_sva
	import axi_sram_pkg::*;
(
	input logic  clk,
	input logic  rstn,
	input logic  ar_ready_o,
	input data_t r_data_o,
	input resp_t r_resp_o,
	input logic  r_valid_o,
	input logic  r_ready_i,
	input resp_t b_resp_o,
	input logic  b_valid_o,
	input logic  b_ready_i
);

	// covers reset itself and the first cycle after it
	a_quiet_reset: assert property (@(posedge clk)
		!rstn |=> !r_valid_o && !b_valid_o)
		else $error("response valid during or just after reset");

	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
		else $error("read response dropped or changed while stalled");

	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
		else $error("write response dropped or changed while stalled");

	a_one_channel: assert property (@(posedge clk) disable iff (!rstn)
		!(r_valid_o && b_valid_o))
		else $error("read and write responses valid together");

	// one transaction in flight
	a_no_accept_pending: assert property (@(posedge clk) disable iff (!rstn)
		(r_valid_o || b_valid_o) |-> !ar_ready_o)
		else $error("read address ready while a response is pending");

endmodule

`default_nettype wire

//--- axi_sram_tb.sv
//**********************************************************
// testbench of the AXI-lite style SRAM slave
// data file reader, AR/AW/W drivers, R/B collection
// with random back-pressure, compare tasks, watchdog
//**********************************************************

`timescale 1ns/10ps
`default_nettype none

module axi_sram_tb
	import axi_sram_pkg::*;
();

	localparam int          CLK_PERIOD = 4;
	localparam int          RST_CYCLES = 2;
	localparam logic [31:0] LCG_SEED   = 32'h93ec_171b;

	logic  clk, rstn;
	addr_t ar_addr_i;
	logic  ar_valid_i, ar_ready_o;
	data_t r_data_o;
	resp_t r_resp_o, b_resp_o;
	logic  r_valid_o, r_ready_i;
	addr_t aw_addr_i;
	logic  aw_valid_i, aw_ready_o;
	data_t w_data_i;
	strb_t w_strb_i;
	logic  w_valid_i, w_ready_o;
	logic  b_valid_o, b_ready_i;

	byte         op_q[$];
	addr_t       addr_q[$];
	data_t       wdata_q[$];
	strb_t       strb_q[$];
	data_t       exp_data_q[$];
	resp_t       exp_resp_q[$];
	int          n_lines   = 0;
	int          errors    = 0;
	logic [31:0] lcg_state = LCG_SEED;

	axi_sram_top uut (.*);

	bind axi_sram_top axi_sram_sva u_sva (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic stop_run();
		errors++;
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;    // low bits of an LCG cycle too fast
	endfunction

	task automatic check_data(input string name, input data_t exp_v, input data_t act_v);
		if (act_v !== exp_v) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp_v, input resp_t act_v);
		if (act_v !== exp_v) begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp_v, act_v);
			stop_run();
		end
	endtask

	task automatic load_testdata();
		int          fd;
		int          c;
		byte         op;
		logic [31:0] a, d, e;
		logic [3:0]  s;
		logic [1:0]  r;
		fd = $fopen("axi_sram_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file axi_sram_testdata.txt");
			stop_run();
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				c = 0;
				while (c != "\n" && c != -1)    // skip the column notes
					c = $fgetc(fd);
			end else if ((op != "R" && op != "W" && op != "P") ||
					$fscanf(fd, "%h %h %h %h %h", a, d, s, e, r) != 5) begin
				$display("malformed line in the test data file, operation %c", op);
				stop_run();
			end else begin
				op_q.push_back(op);
				addr_q.push_back(a);
				wdata_q.push_back(d);
				strb_q.push_back(s);
				exp_data_q.push_back(e);
				exp_resp_q.push_back(resp_t'(r));
			end
		end
		$fclose(fd);
		n_lines = op_q.size();
	endtask

	// returns on the falling edge after the accept edge
	task automatic wait_accept(input logic want_read);
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			#1;
			seen = want_read ? ar_ready_o : (aw_ready_o & w_ready_o);
			if (want_read && (aw_ready_o || w_ready_o)) begin
				$display("write channel ready next to a pending read at %0t", $time);
				stop_run();
			end
			if (!seen)
				@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic collect_resp(input logic is_read, output data_t d, output resp_t r);
		int   stall;
		int   n;
		logic hs;
		stall = int'(lcg_next() % 8);
		n     = 0;
		hs    = 1'b0;
		d     = '0;
		r     = RESP_OKAY;
		while (!hs) begin
			r_ready_i = is_read && (n >= stall);
			b_ready_i = !is_read && (n >= stall);
			#1;
			if (ar_ready_o || aw_ready_o || w_ready_o) begin
				$display("address ready came up while a response was pending at %0t", $time);
				stop_run();
			end
			hs = is_read ? (r_valid_o & r_ready_i) : (b_valid_o & b_ready_i);
			if (hs) begin
				d = r_data_o;    // stable up to the handshake edge
				r = is_read ? r_resp_o : b_resp_o;
			end else begin
				@(negedge clk);
				n++;
			end
		end
		@(negedge clk);
		r_ready_i = 1'b0;
		b_ready_i = 1'b0;
	endtask

	task automatic read_txn(input int i);
		data_t d;
		resp_t r;
		ar_addr_i  = addr_q[i];
		ar_valid_i = 1'b1;
		wait_accept(1'b1);
		ar_valid_i = 1'b0;
		collect_resp(1'b1, d, r);
		check_data("r_data_o", exp_data_q[i], d);
		check_resp("r_resp_o", exp_resp_q[i], r);
	endtask

	task automatic write_txn(input int i);
		data_t d;
		resp_t r;
		aw_addr_i  = addr_q[i];
		w_data_i   = wdata_q[i];
		w_strb_i   = strb_q[i];
		aw_valid_i = 1'b1;
		w_valid_i  = 1'b1;
		wait_accept(1'b0);
		aw_valid_i = 1'b0;
		w_valid_i  = 1'b0;
		collect_resp(1'b0, d, r);
		check_resp("b_resp_o", exp_resp_q[i], r);
	endtask

	initial begin
		rstn       = 1'b0;
		ar_addr_i  = '0;
		ar_valid_i = 1'b0;
		r_ready_i  = 1'b0;
		aw_addr_i  = '0;
		aw_valid_i = 1'b0;
		w_data_i   = '0;
		w_strb_i   = '0;
		w_valid_i  = 1'b0;
		b_ready_i  = 1'b0;
		load_testdata();
		if (n_lines == 0) begin
			$display("no transactions found in the test data file");
			stop_run();
		end
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			repeat (lcg_next() % 4) @(negedge clk);    // idle gap
			case (op_q[i])
				"R": read_txn(i);
				"W": write_txn(i);
				default: begin
					// write presented with the read, must wait behind it
					aw_addr_i  = addr_q[i];
					aw_valid_i = 1'b1;
					w_valid_i  = 1'b1;
					read_txn(i);
					write_txn(i);
				end
			endcase
		end
		if (errors == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "errors were found");
		end
	end

	// 40 cycles per transaction is far above the worst average
	initial begin
		wait (n_lines > 0);
		#((n_lines * 40 + RST_CYCLES) * CLK_PERIOD);
		$display("timeout: transaction never completed");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- axi_sram_top.f
+incdir+.
axi_sram_pkg.sv
axi_sram_if.sv
delay_lfsr.sv
axi_sram_req_stage.sv
axi_sram_array.sv
axi_sram_rsp_stage.sv
axi_sram_top.sv
axi_sram_sva.sv
axi_sram_tb.sv

//--- axi_sram_testdata.txt
# op addr wdata strb exp_rdata exp_resp, all hex; op R read, W write, P read+write same cycle
# exp_resp 0 is OKAY, 2 is SLVERR; on P lines exp_rdata is the value before the write
W 00000000 11223344 f 00000000 0
W 00000004 a5a5a5a5 f 00000000 0
W 000003fc deadbeef f 00000000 0
R 00000000 00000000 0 11223344 0
R 00000004 00000000 0 a5a5a5a5 0
R 000003fe 00000000 0 deadbeef 0
W 00000010 cafef00d f 00000000 0
W 00000011 00000077 1 00000000 0
W 00000012 12340000 c 00000000 0
R 00000010 00000000 0 1234f077 0
W 00000008 00000000 f 00000000 0
W 00000008 0000ab00 2 00000000 0
W 00000008 ffffffff 0 00000000 0
R 00000008 00000000 0 0000ab00 0
W 00000020 00000000 f 00000000 0
W 00000020 aabbccdd 5 00000000 0
W 00000020 11223344 a 00000000 0
R 00000020 00000000 0 11bb33dd 0
R 00000400 00000000 0 00000000 2
W 00000400 ffffffff f 00000000 2
W 00001000 55555555 f 00000000 2
R 00000000 00000000 0 11223344 0
P 00000004 0f0f0f0f f a5a5a5a5 0
R 00000004 00000000 0 0f0f0f0f 0
P 00000800 77777777 f 00000000 2
R 00000000 00000000 0 11223344 0
P 000003fc 00000000 3 deadbeef 0
R 000003fc 00000000 0 dead0000 0
R fffffffc 00000000 0 00000000 2
